// ==== vlog.f ====
logic/robPkg.sv
logic/trapPkg.sv
logic/renameDispatch.sv
logic/reorderFifo.sv
logic/writebackLog.sv
logic/commitUnit.sv
logic/trapCsr.sv
logic/commitTop.sv
testbench/commitTb.sv

// ==== Makefile ====
# Verilator build and run for the retirement path testbench

TOP = commitTb

all: run

build:
	verilator --binary --timing --assert -Wno-fatal -f vlog.f --top-module $(TOP) -o $(TOP)Sim

run: build
	./obj_dir/$(TOP)Sim | tee /dev/stderr | grep -q "All checks passed"

lint:
	verilator --lint-only --timing -Wall -f vlog.f --top-module $(TOP)

clean:
	rm -rf obj_dir

.PHONY: all build run lint clean

// ==== testbench/commitTb.sv ====
// Testbench for the retirement path
// Models the reorder FIFO, rename copies and machine CSRs and checks every edge
`timescale 1ns/1ns

module commitTb;
	import robPkg::*;
	import trapPkg::*;

	typedef struct packed {
		robEntryT e;
		logic wb;
		logic sent;
		logic fault;
		logic misAl;
	} modelEntryT;

	typedef struct packed {
		logic commit;
		logic redirect;
		logic trap;
		logic xret;
		logic isInt;
		causeT cause;
		pcT target;
	} expectT;

	logic clk;
	logic rstN;
	logic dispatchValid;
	dispatchT dispatchIn;
	logic dispatchReady;
	writebackT writebackIn;
	logic isMisPredict;
	pcT misPredictTarget;
	logic csrWrite;
	csrAddrT csrAddr;
	logic [63:0] csrData;
	logic commitValid;
	pcT commitPc;
	archRegT commitRd;
	logic redirectValid;
	pcT redirectPc;

	// Reference state
	modelEntryT modelQ[$];
	slotT tbPtr [32];
	logic [RP-1:0] tbBusy [32];
	csrViewT csrM;
	logic accepted;
	logic hung;
	int commitCount;
	int redirectCount;
	int stallCount;
	int valueErrors;
	int otherErrors;
	logic [31:0] rngState;
	pcT nextPc;

	commitTop dut_i (
		.clk(clk), .rstN(rstN),
		.dispatchValid(dispatchValid), .dispatchIn(dispatchIn),
		.dispatchReady(dispatchReady),
		.writebackIn(writebackIn), .isMisPredict(isMisPredict),
		.misPredictTarget(misPredictTarget),
		.csrWrite(csrWrite), .csrAddr(csrAddr), .csrData(csrData),
		.commitValid(commitValid), .commitPc(commitPc), .commitRd(commitRd),
		.redirectValid(redirectValid), .redirectPc(redirectPc)
	);

	always #20 clk = ~clk;

	function automatic logic [31:0] nextRand();
		rngState = rngState * 32'd1664525 + 32'd1013904223;
		return rngState;
	endfunction

	// Lowest free copy with a valid bit on top
	function automatic logic [RB:0] lowestFree(input archRegT rd);
		logic [RB:0] res;
		res = '0;
		for (int i = RP - 1; i >= 0; i--) begin
			if (!tbBusy[rd][i]) res = {1'b1, slotT'(i)};
		end
		return res;
	endfunction

	// Expected outcome at the head for one edge
	function automatic expectT expectAt(input modelEntryT h, input logic present,
		input csrViewT c, input logic misPred, input pcT tgt);
		expectT ex;
		logic [63:0] pend;
		ex = '0;
		pend = c.mip & c.mie & 64'h888;
		if (!present) return ex;
		ex.target = c.mtvec;
		ex.trap = 1'b1;
		ex.redirect = 1'b1;
		if (c.mstatus[3] && pend != 0) begin
			ex.isInt = 1'b1;
			// MEI over MSI over MTI
			if (pend[11]) ex.cause = 63'd11;
			else if (pend[3]) ex.cause = 63'd3;
			else ex.cause = 63'd7;
		end else if (h.e.isEbreak) ex.cause = 63'd3;
		else if (h.e.isEcall) ex.cause = 63'd11;
		else if (h.e.isIllegal) ex.cause = 63'd2;
		else if (h.e.isInstrAccessFault) ex.cause = 63'd1;
		else if (!h.wb && h.fault && h.e.isLu) ex.cause = 63'd5;
		else if (!h.wb && h.fault && h.e.isSu) ex.cause = 63'd7;
		else if (!h.wb && h.misAl && h.e.isLu) ex.cause = 63'd4;
		else if (!h.wb && h.misAl && h.e.isSu) ex.cause = 63'd6;
		else begin
			ex.trap = 1'b0;
			ex.redirect = 1'b0;
			if (h.e.isMret) begin
				ex.xret = 1'b1;
				ex.redirect = 1'b1;
				ex.target = c.mepc;
			end else if (h.wb && h.e.isBranch && misPred) begin
				ex.redirect = 1'b1;
				ex.target = tgt;
			end else if (h.wb) begin
				ex.commit = 1'b1;
			end
		end
		return ex;
	endfunction

	task automatic compareValue(input string name, input logic [63:0] got,
		input logic [63:0] exp);
		assert (got === exp) else begin
			valueErrors++;
			$display("FAIL t=%0t %s got %0h exp %0h", $time, name, got, exp);
		end
	endtask

	task automatic requireTrue(input logic cond, input string msg);
		assert (cond) else begin
			otherErrors++;
			$display("ERROR t=%0t %s", $time, msg);
		end
	endtask

	// Compare just before the rising edge and advance the model past it
	task automatic checkEdge();
		modelEntryT h;
		modelEntryT tmp;
		logic present;
		expectT ex;
		logic [RB:0] fr;
		logic pushNow;
		archRegT a;
		present = modelQ.size() > 0;
		h = present ? modelQ[0] : '0;
		ex = expectAt(h, present, csrM, isMisPredict, misPredictTarget);
		fr = lowestFree(dispatchIn.rd);
		compareValue("dispatchReady", dispatchReady,
			(modelQ.size() < FIFO_DEPTH) && fr[RB] && !ex.redirect);
		compareValue("commitValid", commitValid, ex.commit);
		compareValue("redirectValid", redirectValid, ex.redirect);
		if (ex.commit) begin
			compareValue("commitPc", commitPc, h.e.pc);
			compareValue("commitRd", commitRd, h.e.rd[RB +: 5]);
		end
		if (ex.redirect) compareValue("redirectPc", redirectPc, ex.target);
		compareValue("mepc", dut_i.csrView.mepc, csrM.mepc);
		compareValue("mcause", dut_i.csrView.mcause, csrM.mcause);
		compareValue("mstatus", dut_i.csrView.mstatus, csrM.mstatus);
		pushNow = dispatchValid && dispatchReady;
		accepted = pushNow;
		if (dispatchValid && !dispatchReady) stallCount++;
		// Writeback flags land at this edge
		if (writebackIn.valid) begin
			for (int i = 0; i < modelQ.size(); i++) begin
				if (modelQ[i].e.rd == writebackIn.rd) begin
					tmp = modelQ[i];
					tmp.wb = !(writebackIn.lsuAccessFault || writebackIn.lsuMisAlign);
					tmp.fault = writebackIn.lsuAccessFault;
					tmp.misAl = writebackIn.lsuMisAlign;
					modelQ[i] = tmp;
				end
			end
		end
		if (csrWrite) begin
			case (csrAddr)
				CSR_MSTATUS: csrM.mstatus = csrData;
				CSR_MIE: csrM.mie = csrData;
				CSR_MIP: csrM.mip = csrData;
				CSR_MEPC: csrM.mepc = csrData;
				CSR_MCAUSE: csrM.mcause = csrData;
				CSR_MTVEC: csrM.mtvec = csrData;
				default: ;
			endcase
		end
		if (ex.commit) begin
			a = h.e.rd[RB +: 5];
			tbBusy[a][tbPtr[a]] = 1'b0;
			tbPtr[a] = h.e.rd[RB-1:0];
			void'(modelQ.pop_front());
			commitCount++;
		end
		if (ex.trap) begin
			csrM.mepc = h.e.pc;
			csrM.mcause = {ex.isInt, ex.cause};
			csrM.mstatus[7] = csrM.mstatus[3];
			csrM.mstatus[3] = 1'b0;
			csrM.mstatus[12:11] = 2'b11;
		end else if (ex.xret) begin
			csrM.mstatus[3] = csrM.mstatus[7];
			csrM.mstatus[7] = 1'b1;
		end
		if (ex.redirect) begin
			redirectCount++;
			modelQ.delete();
			// Committed copies stay busy
			for (int i = 0; i < 32; i++) tbBusy[i] = RP'(1) << tbPtr[i];
		end else if (pushNow) begin
			tmp = '0;
			// Eight flags sit in the low bits of both entry layouts
			tmp.e = {dispatchIn.pc, dispatchIn.rd, fr[RB-1:0], dispatchIn[7:0]};
			tbBusy[dispatchIn.rd][fr[RB-1:0]] = 1'b1;
			modelQ.push_back(tmp);
		end
	endtask

	always begin
		@(negedge clk);
		#19;
		if (rstN) checkEdge();
	end

	function automatic dispatchT makeInstr(input archRegT rd, input logic [7:0] flags);
		dispatchT d;
		d = {nextPc, rd, flags};
		nextPc = nextPc + 64'd4;
		return d;
	endfunction

	task automatic timedOut(input string what);
		otherErrors++;
		hung = 1'b1;
		$display("ERROR t=%0t timed out waiting for %s", $time, what);
	endtask

	task automatic writeCsr(input csrAddrT addr, input logic [63:0] data);
		@(negedge clk);
		csrWrite = 1'b1;
		csrAddr = addr;
		csrData = data;
		@(negedge clk);
		csrWrite = 1'b0;
	endtask

	task automatic dispatchOne(input dispatchT d);
		int n;
		n = 0;
		@(negedge clk);
		dispatchValid = 1'b1;
		dispatchIn = d;
		do begin
			@(negedge clk);
			n++;
		end while (!accepted && n < 100 && !hung);
		dispatchValid = 1'b0;
		if (!accepted && !hung) timedOut("dispatch acceptance");
	endtask

	// Oldest entry not yet written back
	task automatic writebackOldest(input logic fault, input logic mis);
		modelEntryT tmp;
		int idx;
		idx = -1;
		for (int i = modelQ.size() - 1; i >= 0; i--) begin
			if (!modelQ[i].sent) idx = i;
		end
		@(negedge clk);
		if (idx >= 0) begin
			tmp = modelQ[idx];
			tmp.sent = 1'b1;
			modelQ[idx] = tmp;
			writebackIn = {1'b1, tmp.e.rd, fault, mis};
		end else begin
			requireTrue(1'b0, "no entry left to write back");
		end
		@(negedge clk);
		writebackIn = '0;
	endtask

	task automatic waitRedirect();
		int start;
		int n;
		start = redirectCount;
		n = 0;
		while (redirectCount == start && n < 50 && !hung) begin
			@(negedge clk);
			n++;
		end
		if (redirectCount == start && !hung) timedOut("redirect");
	endtask

	// Random stream with writebacks out of order once wbStart cycles have passed
	task automatic runStream(input int count, input archRegT rdFixed, input int wbStart);
		int sent;
		int cyc;
		int startCommits;
		int cand[$];
		int pick;
		modelEntryT tmp;
		sent = 0;
		cyc = 0;
		startCommits = commitCount;
		while ((sent < count || modelQ.size() > 0) && cyc < 2000 && !hung) begin
			@(negedge clk);
			cyc++;
			if (dispatchValid && accepted) begin
				dispatchValid = 1'b0;
				sent++;
			end
			if (!dispatchValid && sent < count) begin
				dispatchValid = 1'b1;
				dispatchIn = makeInstr(rdFixed != 0 ? rdFixed : archRegT'(1 + nextRand() % 31),
					{nextRand() % 4 == 0, 7'b0});
			end
			writebackIn = '0;
			cand.delete();
			for (int i = 0; i < modelQ.size(); i++) begin
				if (!modelQ[i].sent) cand.push_back(i);
			end
			if (cyc >= wbStart && cand.size() > 0 && nextRand() % 2 == 1) begin
				pick = cand[nextRand() % cand.size()];
				tmp = modelQ[pick];
				tmp.sent = 1'b1;
				modelQ[pick] = tmp;
				writebackIn = {1'b1, tmp.e.rd, 2'b00};
			end
		end
		writebackIn = '0;
		dispatchValid = 1'b0;
		if (cyc >= 2000 && !hung) timedOut("stream drain");
		compareValue("commit count", commitCount - startCommits, count);
	endtask

	initial begin
		clk = 1'b0;
		rstN = 1'b0;
		dispatchValid = 1'b0;
		dispatchIn = '0;
		writebackIn = '0;
		isMisPredict = 1'b0;
		misPredictTarget = '0;
		csrWrite = 1'b0;
		csrAddr = '0;
		csrData = '0;
		accepted = 1'b0;
		hung = 1'b0;
		commitCount = 0;
		redirectCount = 0;
		stallCount = 0;
		valueErrors = 0;
		otherErrors = 0;
		rngState = 32'h1f502f11;
		nextPc = 64'h8000_0000;
		csrM = '0;
		csrM.mstatus = 64'h1800;
		for (int i = 0; i < 32; i++) begin
			tbPtr[i] = '0;
			tbBusy[i] = RP'(1);
		end
		repeat (4) @(posedge clk);
		@(negedge clk);
		rstN = 1'b1;
		writeCsr(CSR_MTVEC, 64'h8000_0100);

		// Ordering under out-of-order writeback
		runStream(40, 5'd0, 0);
		// FIFO full and then every copy of x9 in flight
		stallCount = 0;
		runStream(12, 5'd0, 20);
		requireTrue(stallCount > 0, "no stall seen with a full FIFO");
		stallCount = 0;
		runStream(6, 5'd9, 12);
		requireTrue(stallCount > 0, "no stall seen with all copies busy");

		// Synchronous exceptions behind a normal instruction
		for (int k = 0; k < 4; k++) begin
			dispatchOne(makeInstr(5'd3, 8'h00));
			dispatchOne(makeInstr(5'd4, 8'h01 << (k == 0 ? 4 : k == 1 ? 3 : k == 2 ? 0 : 1)));
			writebackOldest(1'b0, 1'b0);
			waitRedirect();
		end

		// LSU faults with the last one followed by mret
		dispatchOne(makeInstr(5'd4, 8'h40));
		writebackOldest(1'b1, 1'b0);
		waitRedirect();
		dispatchOne(makeInstr(5'd4, 8'h20));
		writebackOldest(1'b1, 1'b0);
		waitRedirect();
		dispatchOne(makeInstr(5'd4, 8'h40));
		writebackOldest(1'b0, 1'b1);
		waitRedirect();
		writeCsr(CSR_MSTATUS, 64'h1808);
		dispatchOne(makeInstr(5'd4, 8'h20));
		writebackOldest(1'b0, 1'b1);
		waitRedirect();
		dispatchOne(makeInstr(5'd0, 8'h04));
		waitRedirect();

		// Timer interrupt, then external over timer, then software
		writeCsr(CSR_MIE, 64'h888);
		writeCsr(CSR_MIP, 64'h80);
		writeCsr(CSR_MSTATUS, 64'h1808);
		dispatchOne(makeInstr(5'd8, 8'h00));
		waitRedirect();
		writeCsr(CSR_MIP, 64'h880);
		writeCsr(CSR_MSTATUS, 64'h1808);
		dispatchOne(makeInstr(5'd8, 8'h00));
		waitRedirect();
		writeCsr(CSR_MIP, 64'h8);
		writeCsr(CSR_MSTATUS, 64'h1808);
		dispatchOne(makeInstr(5'd8, 8'h00));
		waitRedirect();
		// Masked pending bit retires normally
		writeCsr(CSR_MIE, 64'h0);
		writeCsr(CSR_MSTATUS, 64'h1808);
		runStream(3, 5'd8, 0);
		writeCsr(CSR_MIP, 64'h0);

		// Mispredicted branch followed by rollback and more traffic
		dispatchOne(makeInstr(5'd6, 8'h80));
		dispatchOne(makeInstr(5'd6, 8'h00));
		dispatchOne(makeInstr(5'd7, 8'h00));
		isMisPredict = 1'b1;
		misPredictTarget = 64'h8000_4000;
		writebackOldest(1'b0, 1'b0);
		waitRedirect();
		isMisPredict = 1'b0;
		runStream(16, 5'd0, 0);
		runStream(5, 5'd6, 3);

		$display("Errors: %0d (value mismatches %0d, other %0d)",
			valueErrors + otherErrors, valueErrors, otherErrors);
		if (valueErrors + otherErrors == 0) begin
			$display("All checks passed");
		end else begin
			$display("Checks failed");
		end
		$finish;
	end

endmodule

// ==== logic/commitTop.sv ====
// Retirement path top
// Rename, reorder FIFO, writeback log, commit and machine CSRs
`timescale 1ns/1ns

module commitTop (
	input logic clk,
	input logic rstN,
	input logic dispatchValid,
	input robPkg::dispatchT dispatchIn,
	output logic dispatchReady,
	input robPkg::writebackT writebackIn,
	input logic isMisPredict,
	input robPkg::pcT misPredictTarget,
	input logic csrWrite,
	input trapPkg::csrAddrT csrAddr,
	input logic [63:0] csrData,
	output logic commitValid,
	output robPkg::pcT commitPc,
	output robPkg::archRegT commitRd,
	output logic redirectValid,
	output robPkg::pcT redirectPc
);
	import robPkg::*;
	import trapPkg::*;

	logic push;
	logic full;
	logic empty;
	logic pop;
	logic flush;
	logic abort;
	logic commitUpdate;
	logic logClear;
	logic written;
	logic accessFault;
	logic misAlign;
	robEntryT pushEntry;
	robEntryT headEntry;
	physRegT commitReg;
	physRegT clearReg;
	slotT oldSlot;
	trapReqT trapReq;
	csrViewT csrView;

	renameDispatch renameDispatch_i (
		.clk(clk), .rstN(rstN),
		.dispatchValid(dispatchValid), .dispatchIn(dispatchIn),
		.dispatchReady(dispatchReady),
		.full(full), .push(push), .pushEntry(pushEntry),
		.commitUpdate(commitUpdate), .commitReg(commitReg),
		.oldSlot(oldSlot), .abort(abort)
	);

	reorderFifo reorderFifo_i (
		.clk(clk), .rstN(rstN),
		.push(push), .pushEntry(pushEntry),
		.pop(pop), .flush(flush),
		.headEntry(headEntry), .empty(empty), .full(full)
	);

	// Query follows the reorder head
	writebackLog writebackLog_i (
		.clk(clk), .rstN(rstN),
		.writebackIn(writebackIn),
		.logClear(logClear), .clearReg(clearReg),
		.allocValid(push), .allocReg(pushEntry.rd),
		.queryReg(headEntry.rd),
		.written(written), .accessFault(accessFault), .misAlign(misAlign)
	);

	commitUnit commitUnit_i (
		.empty(empty), .headEntry(headEntry), .pop(pop), .flush(flush),
		.written(written), .accessFault(accessFault), .misAlign(misAlign),
		.isMisPredict(isMisPredict),
		.csrView(csrView), .trapReq(trapReq),
		.commitUpdate(commitUpdate), .commitReg(commitReg),
		.logClear(logClear), .clearReg(clearReg),
		.abort(abort),
		.commitValid(commitValid), .commitPc(commitPc), .commitRd(commitRd),
		.oldSlot(oldSlot)
	);

	trapCsr trapCsr_i (
		.clk(clk), .rstN(rstN),
		.trapReq(trapReq),
		.csrWrite(csrWrite), .csrAddr(csrAddr), .csrData(csrData),
		.csrView(csrView),
		.redirectValid(redirectValid), .redirectPc(redirectPc),
		.isMisPredictTarget(misPredictTarget)
	);

endmodule

// ==== logic/trapCsr.sv ====
// Machine CSR file
// Takes traps and mret from commit, drives the fetch redirect
`timescale 1ns/1ns

module trapCsr (
	input logic clk,
	input logic rstN,
	input trapPkg::trapReqT trapReq,
	input logic csrWrite,
	input trapPkg::csrAddrT csrAddr,
	input logic [63:0] csrData,
	output trapPkg::csrViewT csrView,
	output logic redirectValid,
	output robPkg::pcT redirectPc,
	input robPkg::pcT isMisPredictTarget
);
	import robPkg::*;
	import trapPkg::*;

	logic [63:0] mstatus;
	logic [63:0] mie;
	logic [63:0] mip;
	logic [63:0] mcause;
	pcT mepc;
	pcT mtvec;

	assign csrView = '{
		mstatus: mstatus,
		mie: mie,
		mip: mip,
		mepc: mepc,
		mcause: mcause,
		mtvec: mtvec
	};

	// Direct mode only, mtvec MODE bits ignored
	always_comb begin
		redirectValid = trapReq.isTrap | trapReq.isXRet | trapReq.isMisPredict;
		if (trapReq.isTrap) redirectPc = {mtvec[63:2], 2'b00};
		else if (trapReq.isXRet) redirectPc = mepc;
		else redirectPc = isMisPredictTarget;
	end

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			mstatus <= MSTATUS_RESET;
			mie <= '0;
			mip <= '0;
			mepc <= '0;
			mcause <= '0;
			mtvec <= '0;
		end else begin
			// Setup port
			if (csrWrite) begin
				case (csrAddr)
					CSR_MSTATUS: mstatus <= csrData;
					CSR_MIE: mie <= csrData;
					CSR_MIP: mip <= csrData;
					CSR_MEPC: mepc <= csrData;
					CSR_MCAUSE: mcause <= csrData;
					CSR_MTVEC: mtvec <= csrData;
					default: ;
				endcase
			end
			// Trap entry, machine mode only
			if (trapReq.isTrap) begin
				mepc <= trapReq.epc;
				mcause <= {trapReq.isInterrupt, trapReq.cause};
				mstatus[MSTATUS_MPIE] <= mstatus[MSTATUS_MIE];
				mstatus[MSTATUS_MIE] <= 1'b0;
				mstatus[12:11] <= 2'b11;
			end else if (trapReq.isXRet) begin
				mstatus[MSTATUS_MIE] <= mstatus[MSTATUS_MPIE];
				mstatus[MSTATUS_MPIE] <= 1'b1;
			end
		end
	end

	// At most one redirect source per cycle
	assert property (@(posedge clk) disable iff (!rstN)
		$onehot0({trapReq.isTrap, trapReq.isXRet, trapReq.isMisPredict}))
		else $error("conflicting redirect requests");

endmodule

// ==== logic/commitUnit.sv ====
// Commit unit
// Retires the reorder head in order, detects traps, mret and mispredicts
`timescale 1ns/1ns

module commitUnit (
	input logic empty,
	input robPkg::robEntryT headEntry,
	output logic pop,
	output logic flush,
	input logic written,
	input logic accessFault,
	input logic misAlign,
	input logic isMisPredict,
	input trapPkg::csrViewT csrView,
	output trapPkg::trapReqT trapReq,
	output logic commitUpdate,
	output robPkg::physRegT commitReg,
	output logic logClear,
	output robPkg::physRegT clearReg,
	output logic abort,
	output logic commitValid,
	output robPkg::pcT commitPc,
	output robPkg::archRegT commitRd,
	input robPkg::slotT oldSlot
);
	import robPkg::*;
	import trapPkg::*;

	logic headValid;
	logic headWb;
	archRegT headArch;
	logic globalIe;
	logic isExInt;
	logic isTimeInt;
	logic isSoftInt;
	logic isInterrupt;
	logic isLoadFault;
	logic isStoreFault;
	logic isLoadMisAlign;
	logic isStoreMisAlign;
	logic isException;
	logic isTrap;
	logic isXRet;
	logic isBranchAbort;
	logic commitOk;
	causeT cause;

	assign headValid = ~empty;
	assign headWb = headValid & written;
	assign headArch = headEntry.rd[RB +: 5];

	// Machine interrupts, taken at the head
	assign globalIe = csrView.mstatus[MSTATUS_MIE];
	assign isExInt = headValid & csrView.mip[11] & csrView.mie[11] & globalIe;
	assign isTimeInt = headValid & csrView.mip[7] & csrView.mie[7] & globalIe;
	assign isSoftInt = headValid & csrView.mip[3] & csrView.mie[3] & globalIe;
	assign isInterrupt = isExInt | isTimeInt | isSoftInt;

	// LSU faults leave the copy unwritten
	assign isLoadFault = headValid & ~written & accessFault & headEntry.isLu;
	assign isStoreFault = headValid & ~written & accessFault & headEntry.isSu;
	assign isLoadMisAlign = headValid & ~written & misAlign & headEntry.isLu;
	assign isStoreMisAlign = headValid & ~written & misAlign & headEntry.isSu;

	assign isException = (headValid & (headEntry.isEcall | headEntry.isEbreak
		| headEntry.isIllegal | headEntry.isInstrAccessFault))
		| isLoadFault | isStoreFault | isLoadMisAlign | isStoreMisAlign;

	// Fixed priority, interrupts first
	always_comb begin
		cause = '0;
		if (isExInt) cause = CAUSE_MEI;
		else if (isSoftInt) cause = CAUSE_MSI;
		else if (isTimeInt) cause = CAUSE_MTI;
		else if (headEntry.isEbreak) cause = CAUSE_BREAK;
		else if (headEntry.isEcall) cause = CAUSE_ECALL;
		else if (headEntry.isIllegal) cause = CAUSE_ILLEGAL;
		else if (headEntry.isInstrAccessFault) cause = CAUSE_IFAULT;
		else if (isLoadFault) cause = CAUSE_LFAULT;
		else if (isStoreFault) cause = CAUSE_SFAULT;
		else if (isLoadMisAlign) cause = CAUSE_LMISALIGN;
		else if (isStoreMisAlign) cause = CAUSE_SMISALIGN;
	end

	assign isTrap = isInterrupt | isException;
	assign isXRet = headValid & headEntry.isMret & ~isTrap;
	// Branch resolves at its writeback
	assign isBranchAbort = headWb & headEntry.isBranch & isMisPredict & ~isTrap;

	assign abort = isTrap | isXRet | isBranchAbort;
	assign flush = abort;
	assign commitOk = headWb & ~abort;

	assign trapReq = '{
		isTrap: isTrap,
		isXRet: isXRet,
		isMisPredict: isBranchAbort,
		isInterrupt: isInterrupt,
		cause: cause,
		epc: headEntry.pc
	};

	// Retirement and rename update
	assign pop = commitOk;
	assign commitUpdate = commitOk;
	assign commitReg = headEntry.rd;
	assign logClear = commitOk;
	assign clearReg = {headArch, oldSlot};

	assign commitValid = commitOk;
	assign commitPc = headEntry.pc;
	assign commitRd = headArch;

endmodule

// ==== logic/writebackLog.sv ====
// Writeback log
// Written and fault flags per physical register copy
`timescale 1ns/1ns

module writebackLog (
	input logic clk,
	input logic rstN,
	input robPkg::writebackT writebackIn,
	input logic logClear,
	input robPkg::physRegT clearReg,
	input logic allocValid,
	input robPkg::physRegT allocReg,
	input robPkg::physRegT queryReg,
	output logic written,
	output logic accessFault,
	output logic misAlign
);
	import robPkg::*;

	// Indexed by {arch, slot}
	logic [32*RP-1:0] wbFlag;
	logic [32*RP-1:0] faultFlag;
	logic [32*RP-1:0] alignFlag;

	assign written = wbFlag[queryReg];
	assign accessFault = faultFlag[queryReg];
	assign misAlign = alignFlag[queryReg];

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			// Slot 0 holds the reset value of each register
			for (int i = 0; i < 32 * RP; i++) begin
				wbFlag[i] <= (i % RP == 0);
			end
			faultFlag <= '0;
			alignFlag <= '0;
		end else begin
			// Freed copy on commit
			if (logClear) begin
				wbFlag[clearReg] <= 1'b0;
				faultFlag[clearReg] <= 1'b0;
				alignFlag[clearReg] <= 1'b0;
			end
			// Fresh copy, drops stale flags left by a flush
			if (allocValid) begin
				wbFlag[allocReg] <= 1'b0;
				faultFlag[allocReg] <= 1'b0;
				alignFlag[allocReg] <= 1'b0;
			end
			// Faulting access leaves the copy unwritten so commit traps
			if (writebackIn.valid) begin
				wbFlag[writebackIn.rd] <= ~(writebackIn.lsuAccessFault | writebackIn.lsuMisAlign);
				faultFlag[writebackIn.rd] <= writebackIn.lsuAccessFault;
				alignFlag[writebackIn.rd] <= writebackIn.lsuMisAlign;
			end
		end
	end

	// Execution units write each allocated copy once
	assert property (@(posedge clk) disable iff (!rstN)
		writebackIn.valid |-> !wbFlag[writebackIn.rd])
		else $error("writeback to a copy already written");

endmodule

// ==== logic/reorderFifo.sv ====
// Reorder FIFO
// Keeps in-flight instructions in program order, flushed on abort
`timescale 1ns/1ns

module reorderFifo (
	input logic clk,
	input logic rstN,
	input logic push,
	input robPkg::robEntryT pushEntry,
	input logic pop,
	input logic flush,
	output robPkg::robEntryT headEntry,
	output logic empty,
	output logic full
);
	import robPkg::*;

	logic [REORDER_INFO_DW-1:0] mem [FIFO_DEPTH];
	logic [FIFO_AW-1:0] rdPtr;
	logic [FIFO_AW-1:0] wrPtr;
	logic [FIFO_AW:0] count;

	assign empty = (count == '0);
	assign full = (count == (FIFO_AW + 1)'(FIFO_DEPTH));
	// Head valid only when not empty
	assign headEntry = robEntryT'(mem[rdPtr]);

	// Pointers wrap on their own
	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			rdPtr <= '0;
			wrPtr <= '0;
			count <= '0;
		end else if (flush) begin
			rdPtr <= '0;
			wrPtr <= '0;
			count <= '0;
		end else begin
			if (push) begin
				wrPtr <= wrPtr + 1'b1;
			end
			if (pop) begin
				rdPtr <= rdPtr + 1'b1;
			end
			case ({push, pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	// Entry storage
	always_ff @(posedge clk) begin
		if (push && !flush) begin
			mem[wrPtr] <= pushEntry;
		end
	end

	// Commit only retires a present head
	assert property (@(posedge clk) disable iff (!rstN) pop |-> !empty)
		else $error("pop from empty reorder FIFO");

endmodule

// ==== logic/renameDispatch.sv ====
// Rename and dispatch
// Allocates a free copy of the destination register and pushes the reorder entry
`timescale 1ns/1ns

module renameDispatch (
	input logic clk,
	input logic rstN,
	input logic dispatchValid,
	input robPkg::dispatchT dispatchIn,
	output logic dispatchReady,
	input logic full,
	output logic push,
	output robPkg::robEntryT pushEntry,
	input logic commitUpdate,
	input robPkg::physRegT commitReg,
	output robPkg::slotT oldSlot,
	input logic abort
);
	import robPkg::*;

	// Committed copy per register
	slotT archPtr [32];
	// In-flight and committed copies
	logic [RP-1:0] busy [32];
	slotT freeSlot;
	logic hasFree;

	// Lowest free copy of rd
	always_comb begin
		freeSlot = '0;
		hasFree = 1'b0;
		for (int i = RP - 1; i >= 0; i--) begin
			if (!busy[dispatchIn.rd][i]) begin
				freeSlot = slotT'(i);
				hasFree = 1'b1;
			end
		end
	end

	// Held off during an abort so a flushed push is never accepted
	assign dispatchReady = ~full & hasFree & ~abort;
	assign push = dispatchValid & dispatchReady;

	assign pushEntry = '{
		pc: dispatchIn.pc,
		rd: {dispatchIn.rd, freeSlot},
		isBranch: dispatchIn.isBranch,
		isLu: dispatchIn.isLu,
		isSu: dispatchIn.isSu,
		isEcall: dispatchIn.isEcall,
		isEbreak: dispatchIn.isEbreak,
		isMret: dispatchIn.isMret,
		isInstrAccessFault: dispatchIn.isInstrAccessFault,
		isIllegal: dispatchIn.isIllegal
	};

	// Copy displaced by the retiring instruction
	assign oldSlot = archPtr[commitReg[RB +: 5]];

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			for (int i = 0; i < 32; i++) begin
				archPtr[i] <= '0;
				busy[i] <= RP'(1);
			end
		end else if (abort) begin
			// Roll back to the committed mapping
			for (int i = 0; i < 32; i++) begin
				busy[i] <= RP'(1) << archPtr[i];
			end
		end else begin
			if (commitUpdate) begin
				archPtr[commitReg[RB +: 5]] <= commitReg[RB-1:0];
				busy[commitReg[RB +: 5]][oldSlot] <= 1'b0;
			end
			if (push) begin
				busy[dispatchIn.rd][freeSlot] <= 1'b1;
			end
		end
	end

	// Retiring copy is in flight and differs from the committed copy
	assert property (@(posedge clk) disable iff (!rstN)
		commitUpdate |-> busy[commitReg[RB +: 5]][commitReg[RB-1:0]]
			&& commitReg[RB-1:0] != oldSlot)
		else $error("commit of a copy that is not in flight");

endmodule

// ==== logic/trapPkg.sv ====
// Machine trap definitions
// CSR addresses, cause codes and the trap request from commit
package trapPkg;

	typedef logic [11:0] csrAddrT;
	typedef logic [62:0] causeT;

	localparam csrAddrT CSR_MSTATUS = 12'h300;
	localparam csrAddrT CSR_MIE = 12'h304;
	localparam csrAddrT CSR_MTVEC = 12'h305;
	localparam csrAddrT CSR_MEPC = 12'h341;
	localparam csrAddrT CSR_MCAUSE = 12'h342;
	localparam csrAddrT CSR_MIP = 12'h344;

	// mstatus fields, MPP starts at machine
	localparam int MSTATUS_MIE = 3;
	localparam int MSTATUS_MPIE = 7;
	localparam logic [63:0] MSTATUS_RESET = 64'h1800;

	// Exception codes
	localparam causeT CAUSE_ECALL = 63'd11;
	localparam causeT CAUSE_BREAK = 63'd3;
	localparam causeT CAUSE_ILLEGAL = 63'd2;
	localparam causeT CAUSE_IFAULT = 63'd1;
	localparam causeT CAUSE_LFAULT = 63'd5;
	localparam causeT CAUSE_SFAULT = 63'd7;
	localparam causeT CAUSE_LMISALIGN = 63'd4;
	localparam causeT CAUSE_SMISALIGN = 63'd6;
	// Interrupt codes, mcause bit 63 set
	localparam causeT CAUSE_MEI = 63'd11;
	localparam causeT CAUSE_MTI = 63'd7;
	localparam causeT CAUSE_MSI = 63'd3;

	typedef struct packed {
		logic isTrap;
		logic isXRet;
		// Branch redirect without CSR update
		logic isMisPredict;
		logic isInterrupt;
		causeT cause;
		robPkg::pcT epc;
	} trapReqT;

	typedef struct packed {
		logic [63:0] mstatus;
		logic [63:0] mie;
		logic [63:0] mip;
		robPkg::pcT mepc;
		logic [63:0] mcause;
		robPkg::pcT mtvec;
	} csrViewT;

endpackage

// ==== logic/robPkg.sv ====
// Rename and reorder definitions for the retirement path
// Register indices, rename slots and the reorder entry layout
package robPkg;

	// Rename copies per architectural register
	localparam int RB = 2;
	localparam int RP = 4;

	// Reorder FIFO geometry, depth is a power of two
	localparam int FIFO_DEPTH = 8;
	localparam int FIFO_AW = 3;

	typedef logic [4:0] archRegT;
	typedef logic [RB-1:0] slotT;
	// Arch index in the upper bits, slot below
	typedef logic [5+RB-1:0] physRegT;
	typedef logic [63:0] pcT;

	// pc, renamed rd and eight decode flags
	localparam int REORDER_INFO_DW = 64 + 5 + RB + 8;

	typedef struct packed {
		pcT pc;
		physRegT rd;
		logic isBranch;
		logic isLu;
		logic isSu;
		logic isEcall;
		logic isEbreak;
		logic isMret;
		logic isInstrAccessFault;
		logic isIllegal;
	} robEntryT;

	// Decoded instruction before renaming
	typedef struct packed {
		pcT pc;
		archRegT rd;
		logic isBranch;
		logic isLu;
		logic isSu;
		logic isEcall;
		logic isEbreak;
		logic isMret;
		logic isInstrAccessFault;
		logic isIllegal;
	} dispatchT;

	typedef struct packed {
		logic valid;
		physRegT rd;
		logic lsuAccessFault;
		logic lsuMisAlign;
	} writebackT;

endpackage
